// File: Bender.yml
package:
  name: branch_predict_unit

sources:
  - files:
      - hdl/bp_pkg.sv
      - hdl/local_history_predictor.sv
      - hdl/branch_target_buffer.sv
      - hdl/bp_stat_counters.sv
      - hdl/bp_control.sv
      - hdl/branch_predict_unit.sv
  - target: simulation
    files:
      - verification/bpu_asserts.sv
      - verification/tb_branch_predict_unit.sv

// File: filelist.f
hdl/bp_pkg.sv
hdl/local_history_predictor.sv
hdl/branch_target_buffer.sv
hdl/bp_stat_counters.sv
hdl/bp_control.sv
hdl/branch_predict_unit.sv
verification/bpu_asserts.sv
verification/tb_branch_predict_unit.sv

// File: hdl/bp_control.sv
////////////////////////////////////////
// Lookup response register, next fetch
// address and resolve routing.
////////////////////////////////////////

`timescale 1ns/1ps

module bp_control (
  input  logic        clk,
  input  logic        reset,
  input  logic        lookup_valid,
  input  bp_pkg::pc_t lookup_pc,
  output bp_pkg::pc_t tbl_lookup_pc,
  input  logic        pht_taken,
  input  logic        btb_hit,
  input  bp_pkg::pc_t btb_target,
  output logic        resp_valid,
  output logic        resp_taken,
  output logic        resp_btb_hit,
  output bp_pkg::pc_t resp_next_pc,
  input  logic        resolve_valid,
  input  bp_pkg::pc_t resolve_pc,
  input  logic        resolve_taken,
  input  bp_pkg::pc_t resolve_target,
  input  logic        resolve_pred_taken,
  output logic        upd_en,
  output bp_pkg::pc_t upd_pc,
  output logic        upd_taken,
  output logic        btb_wr_en,
  output bp_pkg::pc_t btb_wr_target,
  output logic        mispredict
);

  import bp_pkg::*;

  pc_t next_pc;

  // Both tables are read combinationally in the lookup cycle.
  assign tbl_lookup_pc = lookup_pc;

  // Redirect only when the direction is taken and a target is known.
  assign next_pc = (pht_taken && btb_hit) ? btb_target : lookup_pc + pc_t'(INSTR_BYTES);

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= lookup_valid; // high for the one cycle after each strobe.
    end
  end

  always_ff @(posedge clk) begin
    if (lookup_valid) begin
      resp_taken   <= pht_taken;  // held until the next lookup.
      resp_btb_hit <= btb_hit;
      resp_next_pc <= next_pc;
    end
  end

  // Every resolve trains the direction predictor.
  assign upd_en    = resolve_valid;
  assign upd_pc    = resolve_pc;
  assign upd_taken = resolve_taken;

  assign btb_wr_en     = resolve_valid && resolve_taken; // not-taken branches leave the BTB alone.
  assign btb_wr_target = resolve_target;

  assign mispredict = resolve_valid && (resolve_taken != resolve_pred_taken);

endmodule

// File: hdl/bp_pkg.sv
////////////////////////////////////////
// Shared widths, table sizes and types
// of the branch prediction unit.
////////////////////////////////////////

package bp_pkg;

  localparam int PC_W        = 32;
  localparam int INSTR_BYTES = 4;    // fall-through step of the fetch address.

  // Pattern history table of 2-bit counters.
  localparam int PHT_ENTRIES = 2048;
  localparam int PHT_IDX_W   = $clog2(PHT_ENTRIES);

  localparam int LHT_ENTRIES = 4;    // one history per value of pc[3:2].
  localparam int LHT_IDX_W   = $clog2(LHT_ENTRIES);

  // The BTB index starts above the two instruction offset bits.
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);
  localparam int BTB_TAG_W   = PC_W - BTB_IDX_W - 2;

  localparam int CTR_W  = 2;
  localparam int STAT_W = 32;

  typedef logic [PC_W-1:0]      pc_t;
  typedef logic [CTR_W-1:0]     ctr_t;      // values 2 and 3 predict taken.
  typedef logic [LHT_IDX_W-1:0] lht_idx_t;
  typedef logic [PHT_IDX_W-1:0] hist_t;     // a history is also the counter index.
  typedef logic [BTB_IDX_W-1:0] btb_idx_t;
  typedef logic [BTB_TAG_W-1:0] btb_tag_t;
  typedef logic [STAT_W-1:0]    stat_t;

endpackage

// File: hdl/bp_stat_counters.sv
////////////////////////////////////////
// Resolved branch and mispredict counts.
////////////////////////////////////////

`timescale 1ns/1ps

module bp_stat_counters (
  input  logic          clk,
  input  logic          reset,
  input  logic          branch_en,
  input  logic          mispredict,
  output bp_pkg::stat_t branches,
  output bp_pkg::stat_t mispredicts
);

  // Both counts wrap silently at the top of their range.
  always_ff @(posedge clk) begin
    if (reset) begin
      branches    <= '0;
      mispredicts <= '0;
    end else if (branch_en) begin
      branches <= branches + 1'b1;
      if (mispredict) begin
        mispredicts <= mispredicts + 1'b1; // counted only with a resolve.
      end
    end
  end

endmodule

// File: hdl/branch_predict_unit.sv
////////////////////////////////////////
// Branch prediction unit top level.
////////////////////////////////////////

`timescale 1ns/1ps

module branch_predict_unit (
  input  logic          clk,
  input  logic          reset,
  input  logic          lookup_valid,
  input  bp_pkg::pc_t   lookup_pc,
  output logic          resp_valid,
  output logic          resp_taken,
  output logic          resp_btb_hit,
  output bp_pkg::pc_t   resp_next_pc,
  input  logic          resolve_valid,
  input  bp_pkg::pc_t   resolve_pc,
  input  logic          resolve_taken,
  input  bp_pkg::pc_t   resolve_target,
  input  logic          resolve_pred_taken,
  output logic          mispredict,
  output bp_pkg::stat_t stat_branches,
  output bp_pkg::stat_t stat_mispredicts
);

  import bp_pkg::*;

  pc_t  tbl_lookup_pc;
  logic pht_taken;
  logic btb_hit;
  pc_t  btb_target;
  logic upd_en;
  pc_t  upd_pc;
  logic upd_taken;
  logic btb_wr_en;
  pc_t  btb_wr_target;

  bp_control control_i (
    .clk                (clk),
    .reset              (reset),
    .lookup_valid       (lookup_valid),
    .lookup_pc          (lookup_pc),
    .tbl_lookup_pc      (tbl_lookup_pc),
    .pht_taken          (pht_taken),
    .btb_hit            (btb_hit),
    .btb_target         (btb_target),
    .resp_valid         (resp_valid),
    .resp_taken         (resp_taken),
    .resp_btb_hit       (resp_btb_hit),
    .resp_next_pc       (resp_next_pc),
    .resolve_valid      (resolve_valid),
    .resolve_pc         (resolve_pc),
    .resolve_taken      (resolve_taken),
    .resolve_target     (resolve_target),
    .resolve_pred_taken (resolve_pred_taken),
    .upd_en             (upd_en),
    .upd_pc             (upd_pc),
    .upd_taken          (upd_taken),
    .btb_wr_en          (btb_wr_en),
    .btb_wr_target      (btb_wr_target),
    .mispredict         (mispredict)
  );

  local_history_predictor lhp_i (
    .clk          (clk),
    .reset        (reset),
    .lookup_pc    (tbl_lookup_pc),
    .pred_taken   (pht_taken),
    .update_en    (upd_en),
    .update_pc    (upd_pc),
    .update_taken (upd_taken)
  );

  branch_target_buffer btb_i (
    .clk       (clk),
    .reset     (reset),
    .lookup_pc (tbl_lookup_pc),
    .hit       (btb_hit),
    .target    (btb_target),
    .wr_en     (btb_wr_en),
    .wr_pc     (upd_pc),
    .wr_target (btb_wr_target)
  );

  bp_stat_counters stats_i (
    .clk         (clk),
    .reset       (reset),
    .branch_en   (upd_en),
    .mispredict  (mispredict),
    .branches    (stat_branches),
    .mispredicts (stat_mispredicts)
  );

endmodule

// File: hdl/branch_target_buffer.sv
////////////////////////////////////////
// Direct-mapped tagged branch target
// buffer.
////////////////////////////////////////

`timescale 1ns/1ps

module branch_target_buffer (
  input  logic        clk,
  input  logic        reset,
  input  bp_pkg::pc_t lookup_pc,
  output logic        hit,
  output bp_pkg::pc_t target,
  input  logic        wr_en,
  input  bp_pkg::pc_t wr_pc,
  input  bp_pkg::pc_t wr_target
);

  import bp_pkg::*;

  logic [BTB_ENTRIES-1:0] valid;
  btb_tag_t               tags    [BTB_ENTRIES];
  pc_t                    targets [BTB_ENTRIES];

  btb_idx_t lookup_idx;
  btb_tag_t lookup_tag;
  btb_idx_t wr_idx;
  btb_tag_t wr_tag;

  // Index from pc[5:2], tag from the bits above it.
  assign lookup_idx = lookup_pc[BTB_IDX_W+1:2];
  assign lookup_tag = lookup_pc[PC_W-1:BTB_IDX_W+2];
  assign wr_idx     = wr_pc[BTB_IDX_W+1:2];
  assign wr_tag     = wr_pc[PC_W-1:BTB_IDX_W+2];

  assign hit    = valid[lookup_idx] && (tags[lookup_idx] == lookup_tag);
  assign target = targets[lookup_idx];    // only meaningful when hit is high.

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tags[wr_idx]    <= wr_tag;          // an aliasing branch simply replaces the entry.
      targets[wr_idx] <= wr_target;
    end
  end

endmodule

// File: hdl/local_history_predictor.sv
////////////////////////////////////////
// Two-level local history direction
// predictor with saturating counters.
////////////////////////////////////////

`timescale 1ns/1ps

module local_history_predictor (
  input  logic        clk,
  input  logic        reset,
  input  bp_pkg::pc_t lookup_pc,
  output logic        pred_taken,
  input  logic        update_en,
  input  bp_pkg::pc_t update_pc,
  input  logic        update_taken
);

  import bp_pkg::*;

  hist_t    lht [LHT_ENTRIES];
  ctr_t     pht [PHT_ENTRIES];

  lht_idx_t lookup_idx;
  hist_t    lookup_hist;
  lht_idx_t upd_idx;
  hist_t    upd_hist;
  ctr_t     upd_ctr;
  ctr_t     upd_ctr_next;

  // Lookup path. It only reads the tables, so an update in the same cycle is not seen.
  assign lookup_idx  = lookup_pc[LHT_IDX_W+1:2];
  assign lookup_hist = lht[lookup_idx];
  assign pred_taken  = pht[lookup_hist][CTR_W-1]; // upper counter bit gives the direction.

  // Update path with its own index into both tables.
  assign upd_idx  = update_pc[LHT_IDX_W+1:2];
  assign upd_hist = lht[upd_idx];
  assign upd_ctr  = pht[upd_hist];

  always_comb begin
    upd_ctr_next = upd_ctr;
    if (update_taken) begin
      if (upd_ctr != '1) begin
        upd_ctr_next = upd_ctr + 1'b1; // step up, saturating at 3.
      end
    end else begin
      if (upd_ctr != '0) begin
        upd_ctr_next = upd_ctr - 1'b1; // step down, saturating at 0.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < LHT_ENTRIES; i++) begin
        lht[i] <= '0;
      end
      for (int j = 0; j < PHT_ENTRIES; j++) begin
        pht[j] <= '0;
      end
    end else if (update_en) begin
      // The counter picked by the old history is trained, then the history shifts.
      pht[upd_hist] <= upd_ctr_next;
      lht[upd_idx]  <= {upd_hist[PHT_IDX_W-2:0], update_taken};
    end
  end

endmodule

// File: verification/bpu_asserts.sv
////////////////////////////////////////
// Concurrent checks on response timing,
// next fetch address and mispredict.
////////////////////////////////////////

`timescale 1ns/1ps

module bpu_asserts (
  input logic        clk,
  input logic        reset,
  input logic        lookup_valid,
  input bp_pkg::pc_t lookup_pc,
  input logic        resp_valid,
  input logic        resp_taken,
  input logic        resp_btb_hit,
  input bp_pkg::pc_t resp_next_pc,
  input bp_pkg::pc_t btb_target,
  input logic        resolve_valid,
  input logic        mispredict
);

  import bp_pkg::*;

  int fail_count = 0; // read by the testbench for its summary.

  function automatic void record_failure(input string what);
    fail_count++;
    $error("%s", what);
  endfunction

  resp_after_lookup: assert property (@(posedge clk) disable iff (reset)
    lookup_valid |=> resp_valid) else record_failure("resp_valid missing after a lookup");

  resp_needs_lookup: assert property (@(posedge clk) disable iff (reset)
    resp_valid |-> $past(lookup_valid)) else record_failure("resp_valid without a lookup");

  // The target was read in the lookup cycle, one cycle before the response.
  next_pc_rule: assert property (@(posedge clk) disable iff (reset)
    resp_valid |-> resp_next_pc == ((resp_taken && resp_btb_hit) ? $past(btb_target) :
                                    $past(lookup_pc) + pc_t'(INSTR_BYTES)))
    else record_failure("resp_next_pc breaks the next address rule");

  quiet_mispredict: assert property (@(posedge clk) disable iff (reset)
    !resolve_valid |-> !mispredict) else record_failure("mispredict without a resolve");

endmodule

// File: verification/tb_branch_predict_unit.sv
////////////////////////////////////////
// Testbench of the branch prediction
// unit with a reference model.
////////////////////////////////////////

`timescale 1ns/1ps

module tb_branch_predict_unit;

  import bp_pkg::*;

  localparam int TEST_CYCLES = 2 + 17 + 31 + 27 + 11 + 201; // steps of the six tests.
  localparam int WATCHDOG_NS = (10 + TEST_CYCLES + 50) * 20;

  logic  clk = 1'b0;
  logic  reset = 1'b1;
  logic  lookup_valid = 1'b0;
  pc_t   lookup_pc = '0;
  logic  resolve_valid = 1'b0;
  pc_t   resolve_pc = '0;
  logic  resolve_taken = 1'b0;
  pc_t   resolve_target = '0;
  logic  resolve_pred_taken = 1'b0;
  logic  resp_valid;
  logic  resp_taken;
  logic  resp_btb_hit;
  pc_t   resp_next_pc;
  logic  mispredict;
  stat_t stat_branches;
  stat_t stat_mispredicts;

  // Reference model state.
  hist_t    m_lht [LHT_ENTRIES];
  ctr_t     m_pht [PHT_ENTRIES];
  logic     m_btb_valid [BTB_ENTRIES];
  btb_tag_t m_btb_tag [BTB_ENTRIES];
  pc_t      m_btb_target [BTB_ENTRIES];
  stat_t    m_branches = '0;
  stat_t    m_mispredicts = '0;

  logic exp_valid = 1'b0;
  logic have_resp = 1'b0;
  logic exp_taken;
  logic exp_hit;
  pc_t  exp_next;
  int   seed = 52972;
  int   errors = 0;
  int   err_mark = 0;
  int   asrt_mark = 0;
  int   tests_passed = 0;
  int   tests_failed = 0;
  int   r;

  branch_predict_unit dut_i (.*);

  bind branch_predict_unit bpu_asserts asserts_i (.*);

  always #10 clk = ~clk;

  function automatic void report_error(input string msg);
    $display("[ERROR] %0d ns: %s", $time, msg);
    errors++;
  endfunction

  function automatic logic predict(input pc_t pc);
    return m_pht[m_lht[pc[3:2]]][1]; // upper counter bit.
  endfunction

  function automatic void apply_resolve(input pc_t pc, input logic taken, input pc_t tgt,
                                        input logic pred);
    hist_t h;
    h = m_lht[pc[3:2]];
    if (taken && m_pht[h] != 2'd3) begin
      m_pht[h] = m_pht[h] + 2'd1;
    end else if (!taken && m_pht[h] != 2'd0) begin
      m_pht[h] = m_pht[h] - 2'd1;
    end
    m_lht[pc[3:2]] = {h[PHT_IDX_W-2:0], taken};
    if (taken) begin
      m_btb_valid[pc[5:2]]  = 1'b1;
      m_btb_tag[pc[5:2]]    = pc[31:6];
      m_btb_target[pc[5:2]] = tgt;
    end
    m_branches++;
    if (taken != pred) begin
      m_mispredicts++;
    end
  endfunction

  function automatic void check_outputs();
    assert (resp_valid === exp_valid)
      else report_error($sformatf("resp_valid is %b, expected %b", resp_valid, exp_valid));
    if (have_resp) begin
      assert (resp_taken === exp_taken && resp_btb_hit === exp_hit && resp_next_pc === exp_next)
        else report_error($sformatf("response %b/%b/%h, expected %b/%b/%h", resp_taken,
                                    resp_btb_hit, resp_next_pc, exp_taken, exp_hit, exp_next));
    end
    assert (stat_branches === m_branches && stat_mispredicts === m_mispredicts)
      else report_error($sformatf("statistics %0d/%0d, expected %0d/%0d", stat_branches,
                                  stat_mispredicts, m_branches, m_mispredicts));
  endfunction

  task automatic step(input logic lv, input pc_t lpc, input logic rv, input pc_t rpc,
                      input logic rt, input pc_t rtgt, input logic rpt);
    btb_idx_t bi;
    @(posedge clk);
    #2;
    check_outputs(); // the previous cycle's lookup is now registered.
    lookup_valid       = lv;
    lookup_pc          = lpc;
    resolve_valid      = rv;
    resolve_pc         = rpc;
    resolve_taken      = rt;
    resolve_target     = rtgt;
    resolve_pred_taken = rpt;
    bi        = lpc[5:2];
    exp_valid = lv;
    if (lv) begin
      have_resp = 1'b1;
      exp_taken = predict(lpc); // model still holds the state before this resolve.
      exp_hit   = m_btb_valid[bi] && (m_btb_tag[bi] == lpc[31:6]);
      exp_next  = (exp_taken && exp_hit) ? m_btb_target[bi] : lpc + 32'd4;
    end
    #1;
    assert (mispredict === (rv && (rt != rpt)))
      else report_error($sformatf("mispredict is %b for resolve at %h", mispredict, rpc));
    if (rv) begin
      apply_resolve(rpc, rt, rtgt, rpt);
    end
  endtask

  task automatic lookup_only(input pc_t pc);
    step(1'b1, pc, 1'b0, '0, 1'b0, '0, 1'b0);
  endtask

  task automatic resolve_only(input pc_t pc, input logic taken, input pc_t tgt);
    step(1'b0, '0, 1'b1, pc, taken, tgt, predict(pc));
  endtask

  task automatic idle();
    step(1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b0);
  endtask

  function automatic pc_t rand_pc();
    return pc_t'($random(seed)) & ~32'h3;
  endfunction

  function automatic pc_t pool_pc();
    return 32'h0000_4000 | (pc_t'($random(seed)) & 32'h0000_00fc); // four tags per index.
  endfunction

  task automatic finish_test(input string name);
    if (errors == err_mark && dut_i.asserts_i.fail_count == asrt_mark) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: error", name);
    end
    err_mark  = errors;
    asrt_mark = dut_i.asserts_i.fail_count;
  endtask

  initial begin
    for (int i = 0; i < PHT_ENTRIES; i++) begin
      m_pht[i] = '0;
    end
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      m_btb_valid[i] = 1'b0;
    end
    for (int i = 0; i < LHT_ENTRIES; i++) begin
      m_lht[i] = '0;
    end
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;

    lookup_only(rand_pc());
    idle();
    finish_test("reset state");

    repeat (4) resolve_only(32'h0000_2040, 1'b1, 32'h0000_8800);
    lookup_only(32'h0000_2040);
    repeat (10) resolve_only(32'h0000_2040, 1'b1, 32'h0000_8800); // fill the 11-bit history.
    lookup_only(32'h0000_2040);
    idle();
    finish_test("taken branch with target");

    repeat (3) resolve_only(32'h0000_2040, 1'b1, 32'h0000_8800);
    lookup_only(32'h0000_2040);
    for (int k = 0; k < 2; k++) begin
      resolve_only(32'h0000_2040, 1'b0, 32'h0000_8800); // steps down the all-ones counter.
      repeat (11) resolve_only(32'h0000_2040, 1'b1, 32'h0000_8800); // back to all ones.
      lookup_only(32'h0000_2040);
    end
    idle();
    finish_test("counter saturation");

    for (int i = 0; i < 24; i++) begin
      step(1'b1, 32'h0000_2044, 1'b1, 32'h0000_2044, i[0], 32'h0000_9000,
           predict(32'h0000_2044));
    end
    lookup_only(32'h0000_2040);
    lookup_only(32'h0000_2080); // same BTB index, other tag.
    idle();
    finish_test("local history separation");

    repeat (10) begin
      r = $random(seed);
      step(1'b0, '0, 1'b1, rand_pc(), r[0], rand_pc(), r[1]);
    end
    idle();
    finish_test("mispredict and statistics");

    repeat (200) begin
      r = $random(seed);
      step(r[0], pool_pc(), r[1] | r[2], pool_pc(), r[3], rand_pc(), r[4]);
    end
    idle();
    finish_test("back to back strobes");

    $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
             tests_passed, tests_failed, dut_i.asserts_i.fail_count);
    if (tests_failed == 0 && dut_i.asserts_i.fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all tests finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule
